// File: logic/cdc_axil_regs.sv
/*
 * AXI4-Lite register block in the wr_clk domain
 * Holds the control word, applies byte strobes on writes and
 * returns control, threshold or synchronized status on reads
 * One outstanding write and one outstanding read at a time
 */
`timescale 1ns/100ps

module cdc_axil_regs import cdc_pkg::*; (
   input  logic      wr_clk,
   input  logic      wr_rst_n,
   input  axil_req_t axil_req,   // From the master
   output axil_rsp_t axil_rsp,   // To the master
   input  cdc_stat_t stat_wr,    // Status already in wr_clk
   output cdc_ctrl_t ctrl_wr     // Control word to the synchronizer
);

   logic              wr_accept;   // Address and data taken this cycle
   logic [1:0]        wr_resp;     // Response for the current write
   logic              bvalid_q;
   logic [1:0]        bresp_q;
   logic              rd_accept;   // Read address taken this cycle
   logic [data_w-1:0] rd_data;     // Read mux output
   logic [1:0]        rd_resp;
   logic              rvalid_q;
   logic [data_w-1:0] rdata_q;
   logic [1:0]        rresp_q;

   //**************************************************************************
   // Write channel
   //**************************************************************************
   // Both channels together, blocked while a response waits
   assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;

   always_comb begin
      case (axil_req.awaddr)
         addr_ctrl,
         addr_thresh: wr_resp = resp_okay;
         default:     wr_resp = resp_slverr;   // Status and unmapped
      endcase
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         ctrl_wr  <= '0;
         bvalid_q <= 1'b0;
      end else begin
         if (wr_accept) begin
            bvalid_q <= 1'b1;
            case (axil_req.awaddr)
               addr_ctrl: begin
                  if (axil_req.wstrb[0]) begin          // Both fields in lane 0
                     ctrl_wr.enable    <= axil_req.wdata[0];
                     ctrl_wr.clear_tag <= axil_req.wdata[7:4];
                  end
               end
               addr_thresh: begin
                  if (axil_req.wstrb[0]) begin
                     ctrl_wr.threshold[7:0] <= axil_req.wdata[7:0];
                  end
                  if (axil_req.wstrb[1]) begin
                     ctrl_wr.threshold[15:8] <= axil_req.wdata[15:8];
                  end
               end
               default: ;                               // Nothing changes
            endcase
         end else if (bvalid_q && axil_req.bready) begin
            bvalid_q <= 1'b0;                           // Response taken
         end
      end
   end

   always_ff @(posedge wr_clk) begin
      if (wr_accept) begin
         bresp_q <= wr_resp;
      end
   end

   //**************************************************************************
   // Read channel
   //**************************************************************************
   assign rd_accept = axil_req.arvalid && !rvalid_q;

   // Field packing per register map
   always_comb begin
      rd_data = '0;
      rd_resp = resp_okay;
      case (axil_req.araddr)
         addr_ctrl: begin
            rd_data[0]   = ctrl_wr.enable;
            rd_data[7:4] = ctrl_wr.clear_tag;
         end
         addr_thresh: rd_data[15:0] = ctrl_wr.threshold;
         addr_status: begin
            rd_data[16]   = stat_wr.hit;
            rd_data[15:0] = stat_wr.hit_count;
         end
         default: rd_resp = resp_slverr;              // Unmapped reads zero
      endcase
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         rvalid_q <= 1'b0;
      end else if (rd_accept) begin
         rvalid_q <= 1'b1;
      end else if (rvalid_q && axil_req.rready) begin
         rvalid_q <= 1'b0;
      end
   end

   // Data and response held with rvalid
   always_ff @(posedge wr_clk) begin
      if (rd_accept) begin
         rdata_q <= rd_data;
         rresp_q <= rd_resp;
      end
   end

   //**************************************************************************
   // Response bundle
   //**************************************************************************
   assign axil_rsp = '{
      awready: wr_accept,
      wready:  wr_accept,     // Single beat with the address
      bvalid:  bvalid_q,
      bresp:   bresp_q,
      arready: rd_accept,
      rvalid:  rvalid_q,
      rdata:   rdata_q,
      rresp:   rresp_q
   };

endmodule

// File: logic/cdc_bitsync.sv
/*
 * Single bit synchronizer
 * Chain of flops moving a level signal into the clk domain
 */
`timescale 1ns/100ps

module cdc_bitsync #(
   parameter int sync_stages = 2   // Flops in the chain
) (
   input  logic clk,
   input  logic rst_n,              // Synchronous, active low
   input  logic data_in,            // Level from the other domain
   output logic data_out            // Level in clk domain
);

   logic [sync_stages-1:0] sync_q;  // Stage 0 samples the async input

   //**************************************************************************
   // Shift chain
   //**************************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= data_in;      // Possibly metastable here
         for (int i = 1; i < sync_stages; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign data_out = sync_q[sync_stages-1];  // Last stage is safe to use

endmodule

// File: logic/cdc_cfg_top.sv
/*
 * Configuration and status bridge top level
 * AXI4-Lite registers in wr_clk, event counter in rd_clk,
 * joined by one vector synchronizer in each direction
 */
`timescale 1ns/100ps

module cdc_cfg_top import cdc_pkg::*; #(
   parameter int sync_stages = 2   // Used by both synchronizers
) (
   input  logic      wr_clk,
   input  logic      rd_clk,
   input  logic      wr_rst_n,
   input  logic      rd_rst_n,
   input  axil_req_t axil_req,
   output axil_rsp_t axil_rsp,
   input  logic      event_in      // Synchronous to rd_clk
);

   cdc_ctrl_t ctrl_wr;              // Control in wr_clk
   cdc_ctrl_t ctrl_rd;              // Control in rd_clk
   cdc_stat_t stat_rd;              // Status in rd_clk
   cdc_stat_t stat_wr;              // Status in wr_clk

   //**************************************************************************
   // Write domain registers
   //**************************************************************************
   cdc_axil_regs u_regs (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .stat_wr  (stat_wr),
      .ctrl_wr  (ctrl_wr)
   );

   // Control forward into rd_clk
   cdc_vecsync #(
      .sync_stages (sync_stages),
      .payload_t   (cdc_ctrl_t)
   ) sync_ctrl (
      .wr_clk   (wr_clk),
      .rd_clk   (rd_clk),
      .wr_rst_n (wr_rst_n),
      .rd_rst_n (rd_rst_n),
      .data_in  (ctrl_wr),
      .data_out (ctrl_rd)
   );

   //**************************************************************************
   // Read domain counter
   //**************************************************************************
   rd_event_counter u_counter (
      .rd_clk   (rd_clk),
      .rd_rst_n (rd_rst_n),
      .ctrl_rd  (ctrl_rd),
      .event_in (event_in),
      .stat_rd  (stat_rd)
   );

   // Status back into wr_clk, source side runs on rd_clk
   cdc_vecsync #(
      .sync_stages (sync_stages),
      .payload_t   (cdc_stat_t)
   ) sync_stat (
      .wr_clk   (rd_clk),
      .rd_clk   (wr_clk),
      .wr_rst_n (rd_rst_n),
      .rd_rst_n (wr_rst_n),
      .data_in  (stat_rd),
      .data_out (stat_wr)
   );

endmodule

// File: logic/cdc_pkg.sv
/*
 * CDC configuration bridge package
 * Control and status word layouts, AXI4-Lite channel bundles,
 * register map and response codes shared by the write and read domains
 */
package cdc_pkg;

   //**************************************************************************
   // Field widths
   //**************************************************************************
   localparam int tag_w = 4;    // Clear tag
   localparam int cnt_w = 16;   // Threshold and counter
   localparam int addr_w = 4;   // AXI4-Lite byte address
   localparam int data_w = 32;

   // Control word, written over AXI4-Lite and carried into rd_clk
   typedef struct packed {
      logic             enable;     // Count qualified events
      logic [tag_w-1:0] clear_tag;  // Any change clears the counter
      logic [cnt_w-1:0] threshold;  // Zero disables the hit
   } cdc_ctrl_t;

   // Status word, returned from rd_clk
   typedef struct packed {
      logic             hit;        // Sticky until next clear
      logic [cnt_w-1:0] hit_count;  // Count captured at the hit
   } cdc_stat_t;

   //**************************************************************************
   // AXI4-Lite bundles
   //**************************************************************************
   typedef struct packed {
      logic                  awvalid;
      logic [addr_w-1:0]     awaddr;
      logic                  wvalid;
      logic [data_w-1:0]     wdata;
      logic [data_w/8-1:0]   wstrb;    // One bit per byte lane
      logic                  bready;
      logic                  arvalid;
      logic [addr_w-1:0]     araddr;
      logic                  rready;
   } axil_req_t;                       // Master to slave

   typedef struct packed {
      logic                  awready;
      logic                  wready;
      logic                  bvalid;
      logic [1:0]            bresp;
      logic                  arready;
      logic                  rvalid;
      logic [data_w-1:0]     rdata;
      logic [1:0]            rresp;
   } axil_rsp_t;                       // Slave to master

   // Register map
   localparam logic [addr_w-1:0] addr_ctrl   = 4'h0;  // enable, clear_tag
   localparam logic [addr_w-1:0] addr_thresh = 4'h4;  // threshold
   localparam logic [addr_w-1:0] addr_status = 4'h8;  // Read only

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: logic/cdc_vecsync.sv
/*
 * Vector synchronizer with toggle request and acknowledge
 * Carries a slow changing payload from wr_clk into rd_clk
 * The payload must stay stable for a full handshake round trip
 */
`timescale 1ns/100ps

module cdc_vecsync #(
   parameter int  sync_stages = 2,
   parameter type payload_t   = logic [7:0]
) (
   input  logic     wr_clk,
   input  logic     rd_clk,
   input  logic     wr_rst_n,
   input  logic     rd_rst_n,
   input  payload_t data_in,     // Source domain value
   output payload_t data_out     // Destination domain copy
);

   payload_t data_hold;          // Stable copy while a request is out
   logic     req_wr;             // Toggles once per transfer
   logic     ack_wr;             // Echoed request back in wr_clk
   logic     idle_wr;            // No transfer in flight
   logic     req_rd;             // Request seen in rd_clk
   logic     req_rd_d;           // Previous request, also the acknowledge

   //**************************************************************************
   // Write domain: capture and request
   //**************************************************************************
   assign idle_wr = (req_wr == ack_wr);

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         data_hold <= '0;
         req_wr    <= 1'b0;
      end else begin
         if (idle_wr) begin
            data_hold <= data_in;              // Follows input between rounds
         end
         if (idle_wr && (data_hold != data_in)) begin
            req_wr <= ~req_wr;                 // New value to send
         end
      end
   end

   // Request into rd_clk
   cdc_bitsync #(
      .sync_stages (sync_stages)
   ) u_req_sync (
      .clk      (rd_clk),
      .rst_n    (rd_rst_n),
      .data_in  (req_wr),
      .data_out (req_rd)
   );

   //**************************************************************************
   // Read domain: update and acknowledge
   //**************************************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         data_out <= '0;
         req_rd_d <= 1'b0;
      end else begin
         req_rd_d <= req_rd;
         if (req_rd_d != req_rd) begin
            data_out <= data_hold;             // Held stable by the source
         end
      end
   end

   // Acknowledge back into wr_clk
   cdc_bitsync #(
      .sync_stages (sync_stages)
   ) u_ack_sync (
      .clk      (wr_clk),
      .rst_n    (wr_rst_n),
      .data_in  (req_rd_d),
      .data_out (ack_wr)
   );

endmodule

// File: logic/rd_event_counter.sv
/*
 * Event counter in the rd_clk domain
 * Counts enabled events with saturation and raises a sticky hit
 * when the count reaches a nonzero threshold
 * A change of clear_tag restarts everything
 */
`timescale 1ns/100ps

module rd_event_counter import cdc_pkg::*; (
   input  logic      rd_clk,
   input  logic      rd_rst_n,
   input  cdc_ctrl_t ctrl_rd,    // Synchronized control word
   input  logic      event_in,   // One event per high cycle
   output cdc_stat_t stat_rd     // To the return synchronizer
);

   logic [tag_w-1:0] tag_q;        // Last clear_tag seen
   logic [cnt_w-1:0] count_q;
   logic [cnt_w-1:0] count_next;
   logic             hit_q;
   logic [cnt_w-1:0] hit_count_q;
   logic             tag_change;
   logic             count_inc;
   logic             at_thresh;

   assign tag_change = (ctrl_rd.clear_tag != tag_q);
   assign count_inc  = ctrl_rd.enable && event_in && (count_q != '1);  // Saturate
   assign count_next = count_q + 1'b1;

   // Threshold of zero never hits
   assign at_thresh = (ctrl_rd.threshold != '0) && (count_next == ctrl_rd.threshold);

   //**************************************************************************
   // Counter and sticky hit
   //**************************************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         tag_q       <= '0;          // Matches reset value of ctrl_rd
         count_q     <= '0;
         hit_q       <= 1'b0;
         hit_count_q <= '0;
      end else begin
         tag_q <= ctrl_rd.clear_tag;
         if (tag_change) begin
            count_q     <= '0;      // Event in this cycle is dropped
            hit_q       <= 1'b0;
            hit_count_q <= '0;
         end else if (count_inc) begin
            count_q <= count_next;
            if (!hit_q && at_thresh) begin
               hit_q       <= 1'b1;           // Held until next clear
               hit_count_q <= count_next;
            end
         end
      end
   end

   // Changes at most once per clear
   assign stat_rd = '{
      hit:       hit_q,
      hit_count: hit_count_q
   };

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the CDC bridge testbench with Verilator
# Exit status is nonzero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -f tb.f --top-module cdc_cfg_tb \
   --Mdir "$build_dir" -o cdc_cfg_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/cdc_cfg_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "test passed" "$log"; then
   exit 0
fi
echo "Pass line not found in $log"
exit 1

// File: tb.f
logic/cdc_pkg.sv
logic/cdc_bitsync.sv
logic/cdc_vecsync.sv
logic/cdc_axil_regs.sv
logic/rd_event_counter.sv
logic/cdc_cfg_top.sv
verification/tb_clkgen.sv
verification/cdc_cfg_tb.sv

// File: verification/cdc_cfg_tb.sv
/*
 * Testbench for the CDC configuration bridge
 * AXI4-Lite driver in wr_clk, random event source in rd_clk,
 * register model, status polling with timeouts
 */
`timescale 1ns/100ps

module cdc_cfg_tb import cdc_pkg::*; ();

   localparam int axi_timeout = 50;    // wr_clk cycles per handshake
   localparam int poll_limit  = 200;   // Status reads per poll
   localparam int ev_timeout  = 2000;  // wr_clk cycles for an event burst

   logic      wr_clk;
   logic      rd_clk;
   logic      wr_rst_n;
   logic      rd_rst_n;
   axil_req_t axil_req = '0;
   axil_rsp_t axil_rsp;
   logic      event_in = 1'b0;

   logic       ev_run  = 1'b0;         // Event source on
   int         ev_stop = 0;            // Event count to stop at
   int         ev_sent = 0;            // Events driven so far
   int         errors  = 0;
   int         tests_run = 0;
   int         tests_bad = 0;
   bit         aborted = 1'b0;         // Set by any timeout
   logic       mdl_enable = 1'b0;      // Expected register contents
   logic [3:0] mdl_tag    = '0;
   logic [15:0] mdl_thresh = '0;

   tb_clkgen #(.period(8.0), .phase(0.0), .rst_cycles(5)) wr_clkgen (
      .clk   (wr_clk),
      .rst_n (wr_rst_n)
   );

   tb_clkgen #(.period(8.0), .phase(3.0), .rst_cycles(5)) rd_clkgen (
      .clk   (rd_clk),
      .rst_n (rd_rst_n)
   );

   cdc_cfg_top #(.sync_stages(2)) uut (
      .wr_clk   (wr_clk),
      .rd_clk   (rd_clk),
      .wr_rst_n (wr_rst_n),
      .rd_rst_n (rd_rst_n),
      .axil_req (axil_req),
      .axil_rsp (axil_rsp),
      .event_in (event_in)
   );

   // Random event pulses on about half the cycles
   always @(posedge rd_clk) begin
      logic [31:0] r;
      r = $urandom;
      if (ev_run && (ev_sent < ev_stop) && r[0]) begin
         event_in <= 1'b1;
         ev_sent  <= ev_sent + 1;
      end else begin
         event_in <= 1'b0;
      end
   end

   //**************************************************************************
   // Reporting and model
   //**************************************************************************
   task automatic note_error(input string msg);
      errors++;
      $display("ERR %0t: %s", $time, msg);
   endtask

   task automatic note_timeout(input string what);
      errors++;
      aborted = 1'b1;                  // Later bus cycles are skipped
      $display("Timed out at %0t while waiting for %s", $time, what);
   endtask

   task automatic report_test(input string name, input int base);
      tests_run++;
      if (errors != base) tests_bad++;
      $display("%-16s %s (%0d errors)", name, (errors == base) ? "ok" : "bad", errors - base);
   endtask

   // Control register as read back
   function automatic logic [31:0] ctrl_word();
      return {24'h0, mdl_tag, 3'b000, mdl_enable};
   endfunction

   //**************************************************************************
   // AXI4-Lite master driving on rising edges and sampling on falling edges
   //**************************************************************************
   task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
      int waited;
      resp = 2'bxx;
      if (aborted) return;
      @(posedge wr_clk);
      axil_req.awvalid <= 1'b1;
      axil_req.awaddr  <= addr;
      axil_req.wvalid  <= 1'b1;
      axil_req.wdata   <= data;
      axil_req.wstrb   <= strb;
      waited = 0;
      do begin
         @(negedge wr_clk);
         waited++;
      end while (!(axil_rsp.awready && axil_rsp.wready) && waited < axi_timeout);
      if (!(axil_rsp.awready && axil_rsp.wready)) begin
         note_timeout("write address and data handshake");
         return;
      end
      @(posedge wr_clk);               // Address and data taken here
      axil_req.awvalid <= 1'b0;
      axil_req.wvalid  <= 1'b0;
      axil_req.bready  <= 1'b1;
      waited = 0;
      do begin
         @(negedge wr_clk);
         waited++;
      end while (!axil_rsp.bvalid && waited < axi_timeout);
      if (!axil_rsp.bvalid) begin
         note_timeout("write response");
         return;
      end
      resp = axil_rsp.bresp;
      @(posedge wr_clk);
      axil_req.bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      int waited;
      data = 'x;
      resp = 2'bxx;
      if (aborted) return;
      @(posedge wr_clk);
      axil_req.arvalid <= 1'b1;
      axil_req.araddr  <= addr;
      waited = 0;
      do begin
         @(negedge wr_clk);
         waited++;
      end while (!axil_rsp.arready && waited < axi_timeout);
      if (!axil_rsp.arready) begin
         note_timeout("read address handshake");
         return;
      end
      @(posedge wr_clk);
      axil_req.arvalid <= 1'b0;
      axil_req.rready  <= 1'b1;
      waited = 0;
      do begin
         @(negedge wr_clk);
         waited++;
      end while (!axil_rsp.rvalid && waited < axi_timeout);
      if (!axil_rsp.rvalid) begin
         note_timeout("read data");
         return;
      end
      data = axil_rsp.rdata;
      resp = axil_rsp.rresp;
      @(posedge wr_clk);
      axil_req.rready <= 1'b0;
   endtask

   // Reads status until hit, or until all zero
   task automatic poll_status(input bit want_hit, output logic [31:0] data, output int sent);
      int         polls;
      bit         done;
      logic [1:0] resp;
      polls = 0;
      done  = 1'b0;
      data  = '0;
      sent  = 0;
      while (!done && !aborted && polls < poll_limit) begin
         sent = ev_sent;               // Events driven before this read
         axi_read(addr_status, data, resp);
         done = want_hit ? data[16] : (data == '0);
         polls++;
      end
      if (!done && !aborted) note_timeout(want_hit ? "status hit" : "status clear");
   endtask

   //**************************************************************************
   // Tests
   //**************************************************************************
   task automatic reset_reads();
      logic [31:0] data;
      logic [1:0]  resp;
      int          base;
      base = errors;
      for (int i = 0; i < 3; i++) begin
         axi_read(4'(i * 4), data, resp);         // ctrl, thresh, status
         if (!aborted && (data !== '0 || resp !== resp_okay))
            note_error($sformatf("reset read of %0h gave %h resp %b", i * 4, data, resp));
      end
      report_test("reset values", base);
   endtask

   task automatic register_rw();
      logic [31:0] r;
      logic [31:0] data;
      logic [31:0] exp;
      logic [3:0]  addr;
      logic [1:0]  resp;
      int          base;
      base = errors;
      for (int n = 0; n < 24; n++) begin
         r    = $urandom;
         data = $urandom;
         addr = r[31] ? addr_thresh : addr_ctrl;
         axi_write(addr, data, r[3:0], resp);
         if (!aborted && resp !== resp_okay) note_error("register write not OKAY");
         if (addr == addr_ctrl && r[0]) begin        // Lane 0 holds both fields
            mdl_enable = data[0];
            mdl_tag    = data[7:4];
         end
         if (addr == addr_thresh && r[0]) mdl_thresh[7:0] = data[7:0];
         if (addr == addr_thresh && r[1]) mdl_thresh[15:8] = data[15:8];
         exp = (addr == addr_ctrl) ? ctrl_word() : {16'h0, mdl_thresh};
         axi_read(addr, data, resp);
         if (!aborted && (data !== exp || resp !== resp_okay))
            note_error($sformatf("addr %h read %h expected %h", addr, data, exp));
      end
      // Counting off before the counter tests
      mdl_enable = 1'b0;
      mdl_tag    = '0;
      axi_write(addr_ctrl, 32'h0, 4'hf, resp);
      report_test("register rw", base);
   endtask

   task automatic counting_run();
      logic [31:0] r;
      logic [31:0] data;
      logic [15:0] thr;
      logic [1:0]  resp;
      int          sent;
      int          start;
      int          base;
      base = errors;
      for (int n = 0; n < 4; n++) begin
         r   = $urandom;
         thr = 16'(r % 40 + 1);
         mdl_thresh = thr;
         axi_write(addr_thresh, {16'h0, thr}, 4'h3, resp);
         mdl_tag    = mdl_tag + 1'b1;                // New tag clears the counter
         mdl_enable = 1'b1;
         axi_write(addr_ctrl, ctrl_word(), 4'h1, resp);
         poll_status(1'b0, data, sent);              // Old hit gone
         start   = ev_sent;                          // Events of this round start here
         ev_stop = ev_sent + 100000;
         ev_run  = 1'b1;
         poll_status(1'b1, data, sent);
         ev_run  = 1'b0;
         if (!aborted && data[15:0] !== thr)
            note_error($sformatf("hit_count %0d expected %0d", data[15:0], thr));
         if (!aborted && (sent - start) < int'(thr))
            note_error($sformatf("hit after %0d events, threshold %0d", sent - start, thr));
      end
      report_test("counting", base);
   endtask

   task automatic clear_status();
      logic [31:0] data;
      logic [1:0]  resp;
      int          sent;
      int          base;
      base = errors;
      mdl_tag    = mdl_tag + 1'b1;
      mdl_enable = 1'b0;               // Also disables for the next test
      axi_write(addr_ctrl, ctrl_word(), 4'h1, resp);
      poll_status(1'b0, data, sent);   // Hit must drop after the tag change
      report_test("clear", base);
   endtask

   task automatic disabled_events();
      logic [31:0] data;
      logic [1:0]  resp;
      int          waited;
      int          base;
      base   = errors;
      waited = 0;
      ev_stop = ev_sent + 100;
      ev_run  = 1'b1;
      while (ev_sent < ev_stop && waited < ev_timeout && !aborted) begin
         @(posedge wr_clk);
         waited++;
      end
      ev_run = 1'b0;
      if (!aborted && ev_sent < ev_stop) note_timeout("100 events to be driven");
      for (int i = 0; i < 20; i++) begin           // Settle poll
         axi_read(addr_status, data, resp);
         if (!aborted && data[16] !== 1'b0) note_error("hit set with counting disabled");
      end
      report_test("disabled", base);
   endtask

   task automatic unmapped_access();
      logic [31:0] data;
      logic [1:0]  resp;
      int          base;
      base = errors;
      axi_write(addr_status, $urandom, 4'hf, resp);
      if (!aborted && resp !== resp_slverr) note_error("status write not SLVERR");
      axi_write(4'hc, $urandom, 4'hf, resp);
      if (!aborted && resp !== resp_slverr) note_error("write to 0xC not SLVERR");
      axi_read(4'hc, data, resp);
      if (!aborted && (data !== '0 || resp !== resp_slverr))
         note_error($sformatf("read of 0xC gave %h resp %b", data, resp));
      axi_read(addr_status, data, resp);              // Read only yet OKAY
      if (!aborted && resp !== resp_okay) note_error("status read not OKAY");
      axi_read(addr_ctrl, data, resp);
      if (!aborted && data !== ctrl_word()) note_error("ctrl changed by bad write");
      axi_read(addr_thresh, data, resp);
      if (!aborted && data !== {16'h0, mdl_thresh}) note_error("threshold changed by bad write");
      report_test("unmapped", base);
   endtask

   //**************************************************************************
   // Sequence
   //**************************************************************************
   initial begin
      int waited;
      void'($urandom(6730));
      waited = 0;
      while (!(wr_rst_n && rd_rst_n) && waited < 20) begin
         @(posedge wr_clk);
         waited++;
      end
      if (!(wr_rst_n && rd_rst_n)) note_timeout("reset release");
      reset_reads();
      register_rw();
      counting_run();
      clear_status();
      disabled_events();
      unmapped_access();
      $display("tests run %0d, tests bad %0d, errors %0d", tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: verification/tb_clkgen.sv
/*
 * Testbench clock and reset source
 * Free running clock with a phase offset and a synchronous reset
 */
`timescale 1ns/100ps

module tb_clkgen #(
   parameter real period     = 8.0,
   parameter real phase      = 0.0,   // Delay before the clock starts
   parameter int  rst_cycles = 5      // Rising edges with reset low
) (
   output logic clk,
   output logic rst_n                 // Active low, released on a rising edge
);

   initial begin
      clk = 1'b0;
      #(phase);
      forever begin
         #(period / 2.0) clk = ~clk;
      end
   end

   initial begin
      rst_n = 1'b0;
      repeat (rst_cycles) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule
